// File: rtl/vga_rx_pkg.sv
// shared types and widths for the video receive capture path
// imported by every RTL module of the subsystem

`default_nettype none

package vga_rx_pkg;

    // --------------------
    // fixed widths
    // --------------------
    localparam int ADDRWIDTH  = 7;
    localparam int DATAWIDTH  = 32;
    localparam int PIXWIDTH   = 16;
    localparam int COUNTWIDTH = 16;

    // register map, word addresses
    typedef enum logic [ADDRWIDTH-1:0] {
        REG_RXDATA = 7'd0,
        REG_STATUS = 7'd1,
        REG_CTRL   = 7'd2
    } reg_addr_e;

    // packer waits for the low pixel, then the high pixel
    typedef enum logic {
        PACK_LO = 1'b0,
        PACK_HI = 1'b1
    } pack_state_e;

    // pixel clock domain, one packed word per valid strobe
    typedef struct packed {
        logic                 valid;
        logic [DATAWIDTH-1:0] data;
    } rx_push_t;

    // CTRL register: bits 17..2 threshold, bit 1 flush, bit 0 capture enable
    typedef struct packed {
        logic [COUNTWIDTH-1:0] threshold;
        logic                  flush;
        logic                  capture_en;
    } rx_ctrl_t;

    // STATUS register: count in 15..0, then empty, full, overflow, threshold
    typedef struct packed {
        logic                  thresh_reached;
        logic                  overflow;
        logic                  full;
        logic                  empty;
        logic [COUNTWIDTH-1:0] count;
    } rx_status_t;

endpackage

`default_nettype wire

// File: rtl/vga_pixel_packer.sv
// input side of the capture path, runs on the pixel clock
// packs two RGB565 pixels into one 32-bit word, first pixel in the low half
// capture enable comes from the bus domain and is resynchronized here

`timescale 1ns/1ps
`default_nettype none

module vga_pixel_packer
    import vga_rx_pkg::*;
(
    input  wire                 PCLK_i,
    input  wire                 rx_fifo_cntr_rst,
    input  wire  [PIXWIDTH-1:0] pixel_i,
    input  wire                 pixel_valid_i,
    input  wire                 vsync_i,
    input  wire                 capture_en_i,
    output rx_push_t            push_o
);

    logic [1:0]           en_sync_q;
    logic                 capture_on;
    pack_state_e          state_q;
    logic                 push_valid_q;
    logic [PIXWIDTH-1:0]  low_pix_q;
    logic [DATAWIDTH-1:0] push_data_q;

    // --------------------
    // enable synchronizer
    // --------------------
    always_ff @(posedge PCLK_i or posedge rx_fifo_cntr_rst)
    begin
        if (rx_fifo_cntr_rst)
            en_sync_q <= 2'b00;
        else
            en_sync_q <= {en_sync_q[0], capture_en_i};
    end

    assign capture_on = en_sync_q[1];

    // --------------------
    // pixel pair FSM
    // --------------------
    always_ff @(posedge PCLK_i or posedge rx_fifo_cntr_rst)
    begin
        if (rx_fifo_cntr_rst)
        begin
            state_q      <= PACK_LO;
            push_valid_q <= 1'b0;
        end
        else
        begin
            push_valid_q <= 1'b0;
            // frame start or disabled capture drops any half word
            if (vsync_i || !capture_on)
                state_q <= PACK_LO;
            else if (pixel_valid_i)
            begin
                case (state_q)
                    PACK_LO: state_q <= PACK_HI;
                    PACK_HI:
                    begin
                        state_q      <= PACK_LO;
                        push_valid_q <= 1'b1;
                    end
                    default: state_q <= PACK_LO;
                endcase
            end
        end
    end

    // payload, qualified by the strobe above
    always_ff @(posedge PCLK_i)
    begin
        if (pixel_valid_i && state_q == PACK_LO)
            low_pix_q <= pixel_i;
        if (pixel_valid_i && state_q == PACK_HI)
            push_data_q <= {pixel_i, low_pix_q};
    end

    assign push_o = '{valid: push_valid_q, data: push_data_q};

endmodule

`default_nettype wire

// File: rtl/vga_rx_dc_fifo.sv
// dual-clock FIFO with gray-coded pointers and first-word-fall-through read
// write side on the pixel clock, read side on the bus clock
// flush clears both pointer sets asynchronously

`timescale 1ns/1ps
`default_nettype none

module vga_rx_dc_fifo
    import vga_rx_pkg::*;
#(
    parameter int FIFO_AW = 10
)
(
    input  wire                  wr_clk_i,
    input  wire                  rd_clk_i,
    input  wire                  rx_fifo_cntr_rst,
    input  wire                  flush_i,
    input  wire                  push_i,
    input  wire  [DATAWIDTH-1:0] wdata_i,
    input  wire                  pop_i,
    output logic [DATAWIDTH-1:0] rdata_o,
    output logic                 full_o,
    output logic                 empty_o
);

    localparam int DEPTH = 1 << FIFO_AW;

    logic                 clr;
    logic                 wr_en;
    logic                 rd_en;
    logic [DATAWIDTH-1:0] mem [DEPTH];
    logic [FIFO_AW:0]     wr_bin_q;
    logic [FIFO_AW:0]     wr_gray_q;
    logic [FIFO_AW:0]     rd_bin_q;
    logic [FIFO_AW:0]     rd_gray_q;
    logic [FIFO_AW:0]     rd_gray_w1_q;
    logic [FIFO_AW:0]     rd_gray_w2_q;
    logic [FIFO_AW:0]     wr_gray_r1_q;
    logic [FIFO_AW:0]     wr_gray_r2_q;

    function automatic logic [FIFO_AW:0] bin2gray(input logic [FIFO_AW:0] b);
        return b ^ (b >> 1);
    endfunction

    assign clr   = rx_fifo_cntr_rst | flush_i;
    assign wr_en = push_i & ~full_o;
    assign rd_en = pop_i & ~empty_o;

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge wr_clk_i or posedge clr)
    begin
        if (clr)
        begin
            wr_bin_q     <= '0;
            wr_gray_q    <= '0;
            rd_gray_w1_q <= '0;
            rd_gray_w2_q <= '0;
        end
        else
        begin
            rd_gray_w1_q <= rd_gray_q;
            rd_gray_w2_q <= rd_gray_w1_q;
            if (wr_en)
            begin
                wr_bin_q  <= wr_bin_q + 1'b1;
                wr_gray_q <= bin2gray(wr_bin_q + 1'b1);
            end
        end
    end

    always_ff @(posedge wr_clk_i)
    begin
        if (wr_en)
            mem[wr_bin_q[FIFO_AW-1:0]] <= wdata_i;
    end

    // full when the top two gray bits differ and the rest match
    assign full_o = (wr_gray_q == {~rd_gray_w2_q[FIFO_AW:FIFO_AW-1],
                                   rd_gray_w2_q[FIFO_AW-2:0]});

    // --------------------
    // read side
    // --------------------
    always_ff @(posedge rd_clk_i or posedge clr)
    begin
        if (clr)
        begin
            rd_bin_q     <= '0;
            rd_gray_q    <= '0;
            wr_gray_r1_q <= '0;
            wr_gray_r2_q <= '0;
        end
        else
        begin
            wr_gray_r1_q <= wr_gray_q;
            wr_gray_r2_q <= wr_gray_r1_q;
            if (rd_en)
            begin
                rd_bin_q  <= rd_bin_q + 1'b1;
                rd_gray_q <= bin2gray(rd_bin_q + 1'b1);
            end
        end
    end

    assign empty_o = (rd_gray_q == wr_gray_r2_q);
    // head word shows without a pop
    assign rdata_o = mem[rd_bin_q[FIFO_AW-1:0]];

    // upstream gating must keep both sides in range
    a_no_push_full: assert property (@(posedge wr_clk_i) disable iff (clr)
        push_i |-> !full_o);
    a_no_pop_empty: assert property (@(posedge rd_clk_i) disable iff (clr)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: rtl/vga_rx_fifo_interface.sv
// processing part of the capture path, wraps the dual-clock FIFO
// keeps a bus-domain word count from a push toggle, a threshold flag with
// hysteresis and a sticky overflow flag, all cleared by reset or flush

`timescale 1ns/1ps
`default_nettype none

module vga_rx_fifo_interface
    import vga_rx_pkg::*;
#(
    parameter int FIFO_AW = 10
)
(
    input  wire                  WBs_CLK_i,
    input  wire                  PCLK_i,
    input  wire                  rx_fifo_cntr_rst,
    input  wire  rx_push_t       push_i,
    input  wire                  pop_i,
    input  wire  rx_ctrl_t       ctrl_i,
    output logic [DATAWIDTH-1:0] rdata_o,
    output rx_status_t           status_o
);

    localparam int DEPTH = 1 << FIFO_AW;

    logic                  clr;
    logic                  fifo_full;
    logic                  fifo_empty;
    logic                  push_ok;
    logic                  ovf_pclk_q;
    logic                  ovf_r1_q;
    logic                  ovf_r2_q;
    logic                  push_tgl_q;
    logic [2:0]            tgl_sync_q;
    logic                  push_seen;
    logic [FIFO_AW:0]      count_q;
    logic [COUNTWIDTH-1:0] count_ext;
    logic                  thresh_q;

    assign clr     = rx_fifo_cntr_rst | ctrl_i.flush;
    // a push into a full FIFO is dropped
    assign push_ok = push_i.valid & ~fifo_full;

    vga_rx_dc_fifo #(
        .FIFO_AW          (FIFO_AW)
    ) vga_rx_dc_fifo_inst (
        .wr_clk_i         (PCLK_i),
        .rd_clk_i         (WBs_CLK_i),
        .rx_fifo_cntr_rst (rx_fifo_cntr_rst),
        .flush_i          (ctrl_i.flush),
        .push_i           (push_ok),
        .wdata_i          (push_i.data),
        .pop_i            (pop_i),
        .rdata_o          (rdata_o),
        .full_o           (fifo_full),
        .empty_o          (fifo_empty)
    );

    // --------------------
    // pixel clock side
    // --------------------
    always_ff @(posedge PCLK_i or posedge clr)
    begin
        if (clr)
        begin
            push_tgl_q <= 1'b0;
            ovf_pclk_q <= 1'b0;
        end
        else
        begin
            if (push_ok)
                push_tgl_q <= ~push_tgl_q;
            if (push_i.valid && fifo_full)
                ovf_pclk_q <= 1'b1;
        end
    end

    // --------------------
    // bus clock side
    // --------------------
    always_ff @(posedge WBs_CLK_i or posedge clr)
    begin
        if (clr)
        begin
            tgl_sync_q <= 3'b000;
            ovf_r1_q   <= 1'b0;
            ovf_r2_q   <= 1'b0;
        end
        else
        begin
            tgl_sync_q <= {tgl_sync_q[1:0], push_tgl_q};
            ovf_r1_q   <= ovf_pclk_q;
            ovf_r2_q   <= ovf_r1_q;
        end
    end

    // either edge of the toggle is one accepted word
    assign push_seen = tgl_sync_q[1] ^ tgl_sync_q[2];

    // push and pop together hold the count
    always_ff @(posedge WBs_CLK_i or posedge clr)
    begin
        if (clr)
            count_q <= '0;
        else if (push_seen && !pop_i)
            count_q <= count_q + 1'b1;
        else if (pop_i && !push_seen)
            count_q <= count_q - 1'b1;
    end

    assign count_ext = COUNTWIDTH'(count_q);

    // set at threshold, cleared one below it, otherwise held
    always_ff @(posedge WBs_CLK_i or posedge clr)
    begin
        if (clr)
            thresh_q <= 1'b0;
        else if (count_ext == ctrl_i.threshold)
            thresh_q <= 1'b1;
        else if (count_ext == ctrl_i.threshold - 1'b1)
            thresh_q <= 1'b0;
    end

    assign status_o = '{thresh_reached: thresh_q,
                        overflow:       ovf_r2_q,
                        full:           (count_q == (FIFO_AW+1)'(DEPTH)),
                        empty:          fifo_empty,
                        count:          count_ext};

    // toggle crossing and full gating keep the count within the FIFO
    a_count_in_range: assert property (@(posedge WBs_CLK_i) disable iff (clr)
        count_q <= (FIFO_AW+1)'(DEPTH));

endmodule

`default_nettype wire

// File: rtl/vga_rx_wb_regs.sv
// output side of the capture path, a small bus register block
// acks each strobe one cycle later, pops the FIFO on data reads
// and holds the threshold, flush and capture enable controls

`timescale 1ns/1ps
`default_nettype none

module vga_rx_wb_regs
    import vga_rx_pkg::*;
(
    input  wire                  WBs_CLK_i,
    input  wire                  rx_fifo_cntr_rst,
    input  wire  [ADDRWIDTH-1:0] WBs_ADR_i,
    input  wire                  WBs_CYC_i,
    input  wire  [3:0]           WBs_BYTE_STB_i,
    input  wire                  WBs_WE_i,
    input  wire                  WBs_STB_i,
    input  wire  [DATAWIDTH-1:0] WBs_DAT_i,
    input  wire  [DATAWIDTH-1:0] rdata_i,
    input  wire  rx_status_t     status_i,
    output logic [DATAWIDTH-1:0] WBs_DAT_o,
    output logic                 WBs_ACK_o,
    output logic                 pop_o,
    output rx_ctrl_t             ctrl_o
);

    logic                 req;
    logic                 ack_q;
    logic                 pop_q;
    logic [DATAWIDTH-1:0] dat_q;
    logic [DATAWIDTH-1:0] rd_mux;
    reg_addr_e            addr;
    rx_ctrl_t             ctrl_q;
    rx_ctrl_t             wr_ctrl;

    // new bus cycle not yet acknowledged
    assign req     = WBs_CYC_i & WBs_STB_i & ~ack_q;
    assign addr    = reg_addr_e'(WBs_ADR_i);
    assign wr_ctrl = rx_ctrl_t'(WBs_DAT_i[$bits(rx_ctrl_t)-1:0]);

    // --------------------
    // read data mux
    // --------------------
    always_comb
    begin
        rd_mux = '0;
        case (addr)
            REG_RXDATA: if (!status_i.empty) rd_mux = rdata_i;
            REG_STATUS: rd_mux = DATAWIDTH'(status_i);
            // flush always reads back as zero
            REG_CTRL:   rd_mux = DATAWIDTH'({ctrl_q.threshold, 1'b0, ctrl_q.capture_en});
            default:    rd_mux = '0;
        endcase
    end

    // --------------------
    // ack, pop and control
    // --------------------
    always_ff @(posedge WBs_CLK_i or posedge rx_fifo_cntr_rst)
    begin
        if (rx_fifo_cntr_rst)
        begin
            ack_q  <= 1'b0;
            pop_q  <= 1'b0;
            ctrl_q <= '0;
        end
        else
        begin
            ack_q <= req;
            pop_q <= req & ~WBs_WE_i & (addr == REG_RXDATA) & ~status_i.empty;
            if (req && WBs_WE_i && addr == REG_CTRL)
                ctrl_q <= wr_ctrl;
            else
                ctrl_q.flush <= 1'b0;
        end
    end

    // read word for the ack cycle
    always_ff @(posedge WBs_CLK_i)
    begin
        if (req && !WBs_WE_i)
            dat_q <= rd_mux;
    end

    assign WBs_DAT_o = dat_q;
    assign WBs_ACK_o = ack_q;
    assign pop_o     = pop_q;
    assign ctrl_o    = ctrl_q;

endmodule

`default_nettype wire

// File: rtl/vga_rx_capture_top.sv
// top level of the video receive capture subsystem
// connects the pixel packer, the FIFO interface and the bus registers

`timescale 1ns/1ps
`default_nettype none

module vga_rx_capture_top
    import vga_rx_pkg::*;
#(
    parameter int FIFO_AW = 10
)
(
    input  wire                  WBs_CLK_i,
    input  wire                  PCLK_i,
    input  wire                  rx_fifo_cntr_rst,
    input  wire  [ADDRWIDTH-1:0] WBs_ADR_i,
    input  wire                  WBs_CYC_i,
    input  wire  [3:0]           WBs_BYTE_STB_i,
    input  wire                  WBs_WE_i,
    input  wire                  WBs_STB_i,
    input  wire  [DATAWIDTH-1:0] WBs_DAT_i,
    output logic [DATAWIDTH-1:0] WBs_DAT_o,
    output logic                 WBs_ACK_o,
    input  wire  [PIXWIDTH-1:0]  pixel_i,
    input  wire                  pixel_valid_i,
    input  wire                  vsync_i
);

    rx_push_t             push;
    rx_ctrl_t             ctrl;
    rx_status_t           status;
    logic                 pop;
    logic [DATAWIDTH-1:0] rdata;

    vga_pixel_packer vga_pixel_packer_inst (
        .PCLK_i           (PCLK_i),
        .rx_fifo_cntr_rst (rx_fifo_cntr_rst),
        .pixel_i          (pixel_i),
        .pixel_valid_i    (pixel_valid_i),
        .vsync_i          (vsync_i),
        .capture_en_i     (ctrl.capture_en),
        .push_o           (push)
    );

    vga_rx_fifo_interface #(
        .FIFO_AW          (FIFO_AW)
    ) vga_rx_fifo_interface_inst (
        .WBs_CLK_i        (WBs_CLK_i),
        .PCLK_i           (PCLK_i),
        .rx_fifo_cntr_rst (rx_fifo_cntr_rst),
        .push_i           (push),
        .pop_i            (pop),
        .ctrl_i           (ctrl),
        .rdata_o          (rdata),
        .status_o         (status)
    );

    vga_rx_wb_regs vga_rx_wb_regs_inst (
        .WBs_CLK_i        (WBs_CLK_i),
        .rx_fifo_cntr_rst (rx_fifo_cntr_rst),
        .WBs_ADR_i        (WBs_ADR_i),
        .WBs_CYC_i        (WBs_CYC_i),
        .WBs_BYTE_STB_i   (WBs_BYTE_STB_i),
        .WBs_WE_i         (WBs_WE_i),
        .WBs_STB_i        (WBs_STB_i),
        .WBs_DAT_i        (WBs_DAT_i),
        .rdata_i          (rdata),
        .status_i         (status),
        .WBs_DAT_o        (WBs_DAT_o),
        .WBs_ACK_o        (WBs_ACK_o),
        .pop_o            (pop),
        .ctrl_o           (ctrl)
    );

endmodule

`default_nettype wire

// File: tb/vga_rx_tests.svh
// directed tests plus bus and pixel helpers for the capture testbench
// included inside the testbench module, uses its signals and check task

`ifndef VGA_RX_TESTS_SVH
`define VGA_RX_TESTS_SVH

// --------------------
// bus helpers
// --------------------
task automatic bus_cycle(input reg_addr_e addr, input logic we,
                         input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(negedge WBs_CLK_i);
    WBs_ADR_i      = addr;
    WBs_WE_i       = we;
    WBs_DAT_i      = wdata;
    WBs_BYTE_STB_i = 4'hf;
    WBs_CYC_i      = 1'b1;
    WBs_STB_i      = 1'b1;
    do
    begin
        @(negedge WBs_CLK_i);
        waited++;
    end
    while (!WBs_ACK_o && waited < 16);
    if (!WBs_ACK_o)
    begin
        $display("%s: no acknowledge for bus cycle to address %0d", cur_test, addr);
        errors++;
    end
    rdata          = WBs_DAT_o;
    WBs_CYC_i      = 1'b0;
    WBs_STB_i      = 1'b0;
    WBs_WE_i       = 1'b0;
    WBs_BYTE_STB_i = 4'h0;
endtask

task automatic bus_write(input reg_addr_e addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_cycle(addr, 1'b1, wdata, unused);
endtask

task automatic bus_read(input reg_addr_e addr, output logic [31:0] rdata);
    bus_cycle(addr, 1'b0, 32'd0, rdata);
endtask

task automatic idle_bus(input int cycles);
    repeat (cycles) @(negedge WBs_CLK_i);
endtask

task automatic read_status(output rx_status_t st);
    logic [31:0] d;
    bus_read(REG_STATUS, d);
    st = rx_status_t'(d[19:0]);
endtask

// count 15..0, then empty, full, overflow, threshold reached
function automatic logic [31:0] status_word(input logic [15:0] count, input logic empty,
                                            input logic full, input logic ovf,
                                            input logic thr);
    return {12'd0, thr, ovf, full, empty, count};
endfunction

// word count follows pushes only after the clock crossing
task automatic wait_count(input int target);
    rx_status_t st;
    int         polls;
    polls = 0;
    read_status(st);
    while (32'(st.count) != target && polls < 60)
    begin
        read_status(st);
        polls++;
    end
    if (32'(st.count) != target)
    begin
        $display("%s: word count stuck at %0d, never reached %0d", cur_test, st.count, target);
        errors++;
    end
endtask

// first pixel of each pair is the low half
task automatic check_words(input int n);
    logic [31:0] d;
    int          i;
    for (i = 0; i < n; i++)
    begin
        bus_read(REG_RXDATA, d);
        check_equal({sent_pix[2*i+1], sent_pix[2*i]}, d);
    end
endtask

// --------------------
// pixel helpers
// --------------------
task automatic random_pixel(output logic [15:0] p);
    int r;
    r = $random(seed);
    p = r[15:0];
endtask

task automatic send_pixel(input logic [15:0] p);
    @(negedge PCLK_i);
    pixel_i       = p;
    pixel_valid_i = 1'b1;
    @(negedge PCLK_i);
    pixel_valid_i = 1'b0;
endtask

task automatic send_vsync();
    @(negedge PCLK_i);
    vsync_i = 1'b1;
    @(negedge PCLK_i);
    vsync_i = 1'b0;
endtask

task automatic send_random_pixels(input int n);
    logic [15:0] p;
    repeat (n)
    begin
        random_pixel(p);
        sent_pix.push_back(p);
        send_pixel(p);
    end
endtask

// --------------------
// directed tests
// --------------------
task automatic reset_state_test();
    logic [31:0] d;
    start_test("reset_state");
    bus_read(REG_STATUS, d);
    // threshold resets to 0, which a zero count already meets
    check_equal(status_word(16'd0, 1'b1, 1'b0, 1'b0, 1'b1), d);
    bus_read(REG_CTRL, d);
    check_equal(32'd0, d);
    report_test();
endtask

task automatic packing_order_test();
    logic [31:0] d;
    rx_status_t  st;
    start_test("packing_order");
    sent_pix.delete();
    bus_write(REG_CTRL, 32'd1);
    repeat (4) @(negedge PCLK_i);
    send_random_pixels(2 * PACK_WORDS);
    wait_count(PACK_WORDS);
    check_words(PACK_WORDS);
    // empty FIFO reads as zero and pops nothing
    bus_read(REG_RXDATA, d);
    check_equal(32'd0, d);
    idle_bus(4);
    read_status(st);
    check_equal(32'd0, 32'(st.count));
    report_test();
endtask

task automatic threshold_test();
    logic [31:0] d;
    rx_status_t  st;
    start_test("threshold");
    // threshold field above flush and capture enable
    bus_write(REG_CTRL, 32'(THRESH << 2) | 32'd3);
    idle_bus(4);
    read_status(st);
    check_equal(32'd0, 32'(st.thresh_reached));
    send_random_pixels(2 * THRESH);
    wait_count(THRESH);
    idle_bus(2);
    read_status(st);
    check_equal(32'd1, 32'(st.thresh_reached));
    bus_read(REG_RXDATA, d);
    idle_bus(4);
    read_status(st);
    check_equal(32'(THRESH - 1), 32'(st.count));
    check_equal(32'd0, 32'(st.thresh_reached));
    send_random_pixels(2);
    wait_count(THRESH);
    idle_bus(2);
    read_status(st);
    check_equal(32'd1, 32'(st.thresh_reached));
    report_test();
endtask

task automatic overflow_flush_test();
    rx_status_t st;
    start_test("overflow_flush");
    sent_pix.delete();
    bus_write(REG_CTRL, 32'd3);
    send_random_pixels(2 * (DEPTH + 4));
    wait_count(DEPTH);
    idle_bus(4);
    read_status(st);
    check_equal(32'(DEPTH), 32'(st.count));
    check_equal(32'd1, 32'(st.full));
    check_equal(32'd1, 32'(st.overflow));
    check_equal(32'd0, 32'(st.empty));
    check_words(DEPTH);
    // refill, then flush from full with overflow still set
    send_random_pixels(2 * DEPTH);
    wait_count(DEPTH);
    bus_write(REG_CTRL, 32'd3);
    idle_bus(4);
    read_status(st);
    check_equal(32'd0, 32'(st.count));
    check_equal(32'd0, 32'(st.full));
    check_equal(32'd0, 32'(st.overflow));
    check_equal(32'd1, 32'(st.empty));
    report_test();
endtask

task automatic realign_enable_test();
    logic [31:0] d;
    logic [15:0] lone;
    logic [15:0] a;
    logic [15:0] b;
    rx_status_t  st;
    start_test("realign_enable");
    bus_write(REG_CTRL, 32'd3);
    random_pixel(lone);
    random_pixel(a);
    random_pixel(b);
    send_pixel(lone);
    send_vsync();
    send_pixel(a);
    send_pixel(b);
    wait_count(1);
    bus_read(REG_RXDATA, d);
    check_equal({b, a}, d);
    idle_bus(4);
    read_status(st);
    check_equal(32'd0, 32'(st.count));
    check_equal(32'd1, 32'(st.empty));
    // capture off, pixels must be ignored
    bus_write(REG_CTRL, 32'd0);
    repeat (4) @(negedge PCLK_i);
    send_random_pixels(4);
    idle_bus(20);
    read_status(st);
    check_equal(32'd0, 32'(st.count));
    report_test();
endtask

`endif

// File: tb/tb_vga_rx_capture.sv
// testbench for the video receive capture subsystem
// runs the directed tests from the included task file against the top level
// and prints one line per test, then the closing counts

`timescale 1ns/1ps
`default_nettype none

module tb_vga_rx_capture
    import vga_rx_pkg::*;
();

    localparam int FIFO_AW     = 4;
    localparam int DEPTH       = 1 << FIFO_AW;
    localparam int WB_PERIOD   = 40;
    localparam int PCLK_PERIOD = 30;
    localparam int PACK_WORDS  = 6;
    localparam int THRESH      = 4;

    // --------------------
    // run time budget
    // --------------------
    // rough length of each test in bus cycles
    localparam int LEN_RESET    = 40;
    localparam int LEN_PACKING  = 200;
    localparam int LEN_THRESH   = 250;
    localparam int LEN_OVERFLOW = 600;
    localparam int LEN_REALIGN  = 250;
    localparam int WATCHDOG_NS  = 6 * WB_PERIOD *
        (LEN_RESET + LEN_PACKING + LEN_THRESH + LEN_OVERFLOW + LEN_REALIGN);

    logic                 WBs_CLK_i;
    logic                 PCLK_i;
    logic                 rx_fifo_cntr_rst;
    logic [ADDRWIDTH-1:0] WBs_ADR_i;
    logic                 WBs_CYC_i;
    logic [3:0]           WBs_BYTE_STB_i;
    logic                 WBs_WE_i;
    logic                 WBs_STB_i;
    logic [DATAWIDTH-1:0] WBs_DAT_i;
    logic [DATAWIDTH-1:0] WBs_DAT_o;
    logic                 WBs_ACK_o;
    logic [PIXWIDTH-1:0]  pixel_i;
    logic                 pixel_valid_i;
    logic                 vsync_i;

    int                   errors;
    int                   errors_at_start;
    int                   tests_run;
    int                   tests_failed;
    int                   seed;
    string                cur_test;
    logic [PIXWIDTH-1:0]  sent_pix [$];

    vga_rx_capture_top #(
        .FIFO_AW          (FIFO_AW)
    ) vga_rx_capture_top_inst (
        .WBs_CLK_i        (WBs_CLK_i),
        .PCLK_i           (PCLK_i),
        .rx_fifo_cntr_rst (rx_fifo_cntr_rst),
        .WBs_ADR_i        (WBs_ADR_i),
        .WBs_CYC_i        (WBs_CYC_i),
        .WBs_BYTE_STB_i   (WBs_BYTE_STB_i),
        .WBs_WE_i         (WBs_WE_i),
        .WBs_STB_i        (WBs_STB_i),
        .WBs_DAT_i        (WBs_DAT_i),
        .WBs_DAT_o        (WBs_DAT_o),
        .WBs_ACK_o        (WBs_ACK_o),
        .pixel_i          (pixel_i),
        .pixel_valid_i    (pixel_valid_i),
        .vsync_i          (vsync_i)
    );

    initial
    begin
        WBs_CLK_i = 1'b0;
        forever #(WB_PERIOD / 2) WBs_CLK_i = ~WBs_CLK_i;
    end

    initial
    begin
        PCLK_i = 1'b0;
        forever #(PCLK_PERIOD / 2) PCLK_i = ~PCLK_i;
    end

    task automatic check_equal(input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("FAILED %s: expected %h, actual %h", cur_test, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic report_test();
        tests_run++;
        if (errors == errors_at_start)
            $display("test %s: ok", cur_test);
        else
        begin
            tests_failed++;
            $display("test %s: %0d error(s)", cur_test, errors - errors_at_start);
        end
    endtask

    `include "vga_rx_tests.svh"

    // hard stop if a test never returns
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        errors           = 0;
        errors_at_start  = 0;
        tests_run        = 0;
        tests_failed     = 0;
        seed             = 32'hb622;
        cur_test         = "setup";
        rx_fifo_cntr_rst = 1'b1;
        WBs_ADR_i        = '0;
        WBs_CYC_i        = 1'b0;
        WBs_BYTE_STB_i   = 4'h0;
        WBs_WE_i         = 1'b0;
        WBs_STB_i        = 1'b0;
        WBs_DAT_i        = '0;
        pixel_i          = '0;
        pixel_valid_i    = 1'b0;
        vsync_i          = 1'b0;
        repeat (10) @(negedge WBs_CLK_i);
        rx_fifo_cntr_rst = 1'b0;
        idle_bus(2);

        reset_state_test();
        packing_order_test();
        threshold_test();
        overflow_flush_test();
        realign_enable_test();

        $display("tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+tb
rtl/vga_rx_pkg.sv
rtl/vga_pixel_packer.sv
rtl/vga_rx_dc_fifo.sv
rtl/vga_rx_fifo_interface.sv
rtl/vga_rx_wb_regs.sv
rtl/vga_rx_capture_top.sv
tb/tb_vga_rx_capture.sv

// File: Bender.yml
package:
  name: vga_rx_capture

sources:
  - files:
      - rtl/vga_rx_pkg.sv
      - rtl/vga_pixel_packer.sv
      - rtl/vga_rx_dc_fifo.sv
      - rtl/vga_rx_fifo_interface.sv
      - rtl/vga_rx_wb_regs.sv
      - rtl/vga_rx_capture_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_vga_rx_capture.sv
